// ==== src/frontend_pkg.sv ====
// frontend package with shared widths, opcodes, instruction classes and fetch states
package frontend_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] addr_t;
    typedef logic [XLEN-1:0] instr_t;
    typedef logic [XLEN-1:0] imm_t;
    typedef logic [4:0]      reg_idx_t;

    // --------------------------------------------------------------------
    // queue entry layout, from the top: fault, pc, instruction word
    localparam int FETCH_ENTRY_W   = 1 + XLEN + XLEN;
    localparam int ENTRY_FAULT_BIT = FETCH_ENTRY_W - 1;
    localparam int ENTRY_PC_LSB    = XLEN;

    // --------------------------------------------------------------------
    // RV32I major opcodes
    localparam logic [6:0] OPC_LUI     = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC   = 7'b0010111;
    localparam logic [6:0] OPC_JAL     = 7'b1101111;
    localparam logic [6:0] OPC_JALR    = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH  = 7'b1100011;
    localparam logic [6:0] OPC_LOAD    = 7'b0000011;
    localparam logic [6:0] OPC_STORE   = 7'b0100011;
    localparam logic [6:0] OPC_ALU_IMM = 7'b0010011;
    localparam logic [6:0] OPC_ALU_REG = 7'b0110011;
    localparam logic [6:0] OPC_SYSTEM  = 7'b1110011;

    typedef enum logic [3:0] {
        CLASS_LUI     = 4'd0,
        CLASS_AUIPC   = 4'd1,
        CLASS_JAL     = 4'd2,
        CLASS_JALR    = 4'd3,
        CLASS_BRANCH  = 4'd4,
        CLASS_LOAD    = 4'd5,
        CLASS_STORE   = 4'd6,
        CLASS_ALU_IMM = 4'd7,
        CLASS_ALU_REG = 4'd8,
        CLASS_SYSTEM  = 4'd9,
        CLASS_ILLEGAL = 4'd10
    } instr_class_e;

    // bus: request in flight, hold: word waiting for the queue
    typedef enum logic {
        FETCH_BUS  = 1'b0,
        FETCH_HOLD = 1'b1
    } fetch_state_e;

endpackage

// ==== src/q_fast_ready.sv ====
// ready-valid circular queue whose enq_ready and deq_valid come straight from flops
`timescale 1ns/100ps

module q_fast_ready #(
    parameter int DATA_WIDTH  = 32,
    parameter int NUM_ENTRIES = 4
) (
    input  logic                  CLK,
    input  logic                  nRST,

    // enqueue side
    input  logic                  enq_valid,
    input  logic [DATA_WIDTH-1:0] enq_data,
    output logic                  enq_ready,

    // dequeue side
    output logic                  deq_valid,
    output logic [DATA_WIDTH-1:0] deq_data,
    input  logic                  deq_ready
);

    localparam int PTR_W = $clog2(NUM_ENTRIES);

    // --------------------------------------------------------------------
    // storage and pointers

    logic [DATA_WIDTH-1:0] entries [NUM_ENTRIES];

    logic [PTR_W-1:0] enq_ptr;
    logic [PTR_W-1:0] enq_ptr_next;
    logic [PTR_W-1:0] deq_ptr;
    logic [PTR_W-1:0] deq_ptr_next;
    logic             enq_fire;
    logic             deq_fire;

    assign enq_fire     = enq_valid & enq_ready;
    assign deq_fire     = deq_valid & deq_ready;
    assign enq_ptr_next = enq_ptr + 1'b1;
    assign deq_ptr_next = deq_ptr + 1'b1;

    assign deq_data = entries[deq_ptr];

    always_ff @(posedge CLK) begin
        if (enq_fire) begin
            entries[enq_ptr] <= enq_data;
        end
    end

    // --------------------------------------------------------------------
    // pointers and registered flags

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            enq_ptr   <= '0;
            deq_ptr   <= '0;
            enq_ready <= 1'b1;
            deq_valid <= 1'b0;
        end else begin
            if (enq_fire) begin
                enq_ptr <= enq_ptr_next;
            end
            if (deq_fire) begin
                deq_ptr <= deq_ptr_next;
            end
            // full and empty only move when one side transfers alone
            if (enq_fire && !deq_fire) begin
                enq_ready <= (enq_ptr_next != deq_ptr);
                deq_valid <= 1'b1;
            end
            if (deq_fire && !enq_fire) begin
                enq_ready <= 1'b1;
                deq_valid <= (deq_ptr_next != enq_ptr);
            end
        end
    end

    // head entry must not change under back-pressure
    assert property (@(posedge CLK) disable iff (!nRST)
        deq_valid && !deq_ready |=> deq_valid && $stable(deq_data));

endmodule

// ==== src/fetch_wb_master.sv ====
// sequential instruction fetch over read-only wishbone classic with one word in flight
`timescale 1ns/100ps

module fetch_wb_master #(
    parameter frontend_pkg::addr_t BOOT_PC = 32'h0000_1000
) (
    input  logic                                   CLK,
    input  logic                                   nRST,

    // wishbone classic master, reads only
    output logic                                   wb_cyc,
    output logic                                   wb_stb,
    output frontend_pkg::addr_t                    wb_adr,
    input  frontend_pkg::instr_t                   wb_dat_r,
    input  logic                                   wb_ack,
    input  logic                                   wb_err,

    // towards the fetch queue
    output logic                                   enq_valid,
    output logic [frontend_pkg::FETCH_ENTRY_W-1:0] enq_data,
    input  logic                                   enq_ready
);

    import frontend_pkg::*;

    fetch_state_e state;
    logic         bus_req;
    addr_t        pc;
    instr_t       word_q;
    logic         fault_q;
    logic         bus_done;
    logic         enq_fire;

    assign bus_done = bus_req & (wb_ack | wb_err);
    assign enq_fire = enq_valid & enq_ready;

    // cyc and stb always move together
    assign wb_cyc = bus_req;
    assign wb_stb = bus_req;
    assign wb_adr = pc;

    assign enq_data = {fault_q, pc, word_q};

    // --------------------------------------------------------------------
    // fetch FSM

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            state     <= FETCH_BUS;
            bus_req   <= 1'b0;
            enq_valid <= 1'b0;
            pc        <= BOOT_PC;
        end else begin
            case (state)
                FETCH_BUS: begin
                    if (bus_done) begin
                        state     <= FETCH_HOLD;
                        bus_req   <= 1'b0;
                        enq_valid <= 1'b1;
                    end else begin
                        // also opens the very first request after reset
                        bus_req <= 1'b1;
                    end
                end
                FETCH_HOLD: begin
                    // next request starts on the same edge as the enqueue
                    if (enq_fire) begin
                        state     <= FETCH_BUS;
                        bus_req   <= 1'b1;
                        enq_valid <= 1'b0;
                        pc        <= pc + XLEN'(4);
                    end
                end
                default: begin
                    state <= FETCH_BUS;
                end
            endcase
        end
    end

    // returned word, zeroed on a bus error
    always_ff @(posedge CLK) begin
        if (bus_done) begin
            word_q  <= wb_err ? '0 : wb_dat_r;
            fault_q <= wb_err;
        end
    end

    // --------------------------------------------------------------------
    // bus protocol checks

    // cyc drops for at least one cycle after ack or err
    assert property (@(posedge CLK) disable iff (!nRST)
        wb_cyc && (wb_ack || wb_err) |=> !wb_cyc);

    // address held until ack or err
    assert property (@(posedge CLK) disable iff (!nRST)
        wb_stb && !wb_ack && !wb_err |=> wb_stb && $stable(wb_adr));

endmodule

// ==== src/predecode_stage.sv ====
// predecode register stage that classifies RV32I words and extracts fields and immediates
`timescale 1ns/100ps

module predecode_stage (
    input  logic                                   CLK,
    input  logic                                   nRST,

    // from the fetch queue
    input  logic                                   deq_valid,
    input  logic [frontend_pkg::FETCH_ENTRY_W-1:0] deq_data,
    output logic                                   deq_ready,

    // predecoded output
    output logic                                   dec_valid,
    input  logic                                   dec_ready,
    output frontend_pkg::addr_t                    dec_pc,
    output frontend_pkg::instr_class_e             dec_class,
    output frontend_pkg::reg_idx_t                 dec_rd,
    output frontend_pkg::reg_idx_t                 dec_rs1,
    output frontend_pkg::reg_idx_t                 dec_rs2,
    output frontend_pkg::imm_t                     dec_imm,
    output logic                                   dec_fault
);

    import frontend_pkg::*;

    logic         in_fault;
    addr_t        in_pc;
    instr_t       in_instr;
    logic [6:0]   opcode;
    instr_class_e cls;
    imm_t         imm;
    logic         load_en;

    // --------------------------------------------------------------------
    // unpack queue entry

    assign in_fault = deq_data[ENTRY_FAULT_BIT];
    assign in_pc    = deq_data[ENTRY_PC_LSB +: XLEN];
    assign in_instr = deq_data[XLEN-1:0];
    assign opcode   = in_instr[6:0];

    // class from the major opcode only
    always_comb begin
        case (opcode)
            OPC_LUI:     cls = CLASS_LUI;
            OPC_AUIPC:   cls = CLASS_AUIPC;
            OPC_JAL:     cls = CLASS_JAL;
            OPC_JALR:    cls = CLASS_JALR;
            OPC_BRANCH:  cls = CLASS_BRANCH;
            OPC_LOAD:    cls = CLASS_LOAD;
            OPC_STORE:   cls = CLASS_STORE;
            OPC_ALU_IMM: cls = CLASS_ALU_IMM;
            OPC_ALU_REG: cls = CLASS_ALU_REG;
            OPC_SYSTEM:  cls = CLASS_SYSTEM;
            default:     cls = CLASS_ILLEGAL;
        endcase
    end

    // immediate by format
    always_comb begin
        case (cls)
            CLASS_LOAD, CLASS_ALU_IMM, CLASS_JALR, CLASS_SYSTEM:
                imm = {{20{in_instr[31]}}, in_instr[31:20]};
            CLASS_STORE:
                imm = {{20{in_instr[31]}}, in_instr[31:25], in_instr[11:7]};
            CLASS_BRANCH:
                imm = {{19{in_instr[31]}}, in_instr[31], in_instr[7],
                       in_instr[30:25], in_instr[11:8], 1'b0};
            CLASS_LUI, CLASS_AUIPC:
                imm = {in_instr[31:12], 12'b0};
            CLASS_JAL:
                imm = {{11{in_instr[31]}}, in_instr[31], in_instr[19:12],
                       in_instr[20], in_instr[30:21], 1'b0};
            default:
                imm = '0;
        endcase
    end

    // --------------------------------------------------------------------
    // output register

    assign deq_ready = !dec_valid || dec_ready;
    assign load_en   = deq_valid && deq_ready;

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            dec_valid <= 1'b0;
        end else if (load_en) begin
            dec_valid <= 1'b1;
        end else if (dec_ready) begin
            dec_valid <= 1'b0;
        end
    end

    always_ff @(posedge CLK) begin
        if (load_en) begin
            dec_pc    <= in_pc;
            dec_fault <= in_fault;
            // faulted fetch: illegal with all fields cleared
            dec_class <= in_fault ? CLASS_ILLEGAL : cls;
            dec_rd    <= in_fault ? '0 : in_instr[11:7];
            dec_rs1   <= in_fault ? '0 : in_instr[19:15];
            dec_rs2   <= in_fault ? '0 : in_instr[24:20];
            dec_imm   <= in_fault ? '0 : imm;
        end
    end

    // outputs frozen while the consumer stalls
    assert property (@(posedge CLK) disable iff (!nRST)
        dec_valid && !dec_ready |=> dec_valid && $stable(dec_pc) && $stable(dec_class)
            && $stable(dec_rd) && $stable(dec_rs1) && $stable(dec_rs2)
            && $stable(dec_imm) && $stable(dec_fault));

endmodule

// ==== src/frontend_top.sv ====
// instruction fetch front end chaining wishbone fetch, fetch queue and predecode
`timescale 1ns/100ps

module frontend_top #(
    parameter frontend_pkg::addr_t BOOT_PC     = 32'h0000_1000,
    parameter int                  QUEUE_DEPTH = 4
) (
    input  logic                       CLK,
    input  logic                       nRST,

    // wishbone classic, instruction memory
    output logic                       wb_cyc,
    output logic                       wb_stb,
    output frontend_pkg::addr_t        wb_adr,
    input  frontend_pkg::instr_t       wb_dat_r,
    input  logic                       wb_ack,
    input  logic                       wb_err,

    // predecoded instruction stream
    output logic                       dec_valid,
    input  logic                       dec_ready,
    output frontend_pkg::addr_t        dec_pc,
    output frontend_pkg::instr_class_e dec_class,
    output frontend_pkg::reg_idx_t     dec_rd,
    output frontend_pkg::reg_idx_t     dec_rs1,
    output frontend_pkg::reg_idx_t     dec_rs2,
    output frontend_pkg::imm_t         dec_imm,
    output logic                       dec_fault
);

    import frontend_pkg::*;

    // --------------------------------------------------------------------
    // fetch to queue, queue to predecode

    logic                     enq_valid;
    logic [FETCH_ENTRY_W-1:0] enq_data;
    logic                     enq_ready;
    logic                     deq_valid;
    logic [FETCH_ENTRY_W-1:0] deq_data;
    logic                     deq_ready;

    fetch_wb_master #(
        .BOOT_PC (BOOT_PC)
    ) i_fetch_wb_master (
        .CLK       (CLK),
        .nRST      (nRST),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_adr    (wb_adr),
        .wb_dat_r  (wb_dat_r),
        .wb_ack    (wb_ack),
        .wb_err    (wb_err),
        .enq_valid (enq_valid),
        .enq_data  (enq_data),
        .enq_ready (enq_ready)
    );

    q_fast_ready #(
        .DATA_WIDTH  (FETCH_ENTRY_W),
        .NUM_ENTRIES (QUEUE_DEPTH)
    ) i_q_fast_ready (
        .CLK       (CLK),
        .nRST      (nRST),
        .enq_valid (enq_valid),
        .enq_data  (enq_data),
        .enq_ready (enq_ready),
        .deq_valid (deq_valid),
        .deq_data  (deq_data),
        .deq_ready (deq_ready)
    );

    predecode_stage i_predecode_stage (
        .CLK       (CLK),
        .nRST      (nRST),
        .deq_valid (deq_valid),
        .deq_data  (deq_data),
        .deq_ready (deq_ready),
        .dec_valid (dec_valid),
        .dec_ready (dec_ready),
        .dec_pc    (dec_pc),
        .dec_class (dec_class),
        .dec_rd    (dec_rd),
        .dec_rs1   (dec_rs1),
        .dec_rs2   (dec_rs2),
        .dec_imm   (dec_imm),
        .dec_fault (dec_fault)
    );

endmodule

// ==== verification/tb_clock_gen.sv ====
// testbench clock source with a 10 ns period
`timescale 1ns/100ps

module tb_clock_gen #(
    parameter int HALF_PERIOD_NS = 5
) (
    output logic CLK
);

    initial begin
        CLK = 1'b0;
    end

    always begin
        #(HALF_PERIOD_NS);
        CLK = ~CLK;
    end

endmodule

// ==== verification/frontend_tb.sv ====
// testbench for the fetch front end with a random wishbone memory and a reference predecoder
`timescale 1ns/100ps

module frontend_tb;

    import frontend_pkg::*;

    localparam logic [31:0] BOOT_PC        = 32'h0000_1000;
    localparam int          QUEUE_DEPTH    = 4;
    localparam int          NUM_WORDS      = 256;
    localparam int          TIMEOUT_CYCLES = NUM_WORDS * 12 + 200;
    localparam int          STALL_AT       = 150;
    localparam int          STALL_CYCLES   = 30;

    logic         CLK;
    logic         nRST;
    logic         wb_cyc;
    logic         wb_stb;
    addr_t        wb_adr;
    instr_t       wb_dat_r;
    logic         wb_ack;
    logic         wb_err;
    logic         dec_valid;
    logic         dec_ready;
    addr_t        dec_pc;
    instr_class_e dec_class;
    reg_idx_t     dec_rd;
    reg_idx_t     dec_rs1;
    reg_idx_t     dec_rs2;
    imm_t         dec_imm;
    logic         dec_fault;

    integer       seed;
    instr_t       mem [NUM_WORDS];
    logic [6:0]   opcode_table [11];
    int           wait_left;
    logic         wait_armed;
    int           accepted;
    int           fault_words;
    int           cycles;
    int           bus_beats;
    int           beats_at_stall;
    int           stall_left;
    logic         stall_started;
    logic         restart_wait;
    int           restart_cycles;
    logic         stall_done;

    // snapshot of the outputs while the consumer stalls
    logic         held;
    addr_t        held_pc;
    logic [3:0]   held_class;
    reg_idx_t     held_rd;
    reg_idx_t     held_rs1;
    reg_idx_t     held_rs2;
    imm_t         held_imm;
    logic         held_fault;

    tb_clock_gen i_tb_clock_gen (
        .CLK (CLK)
    );

    frontend_top i_frontend_top (
        .CLK       (CLK),
        .nRST      (nRST),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_adr    (wb_adr),
        .wb_dat_r  (wb_dat_r),
        .wb_ack    (wb_ack),
        .wb_err    (wb_err),
        .dec_valid (dec_valid),
        .dec_ready (dec_ready),
        .dec_pc    (dec_pc),
        .dec_class (dec_class),
        .dec_rd    (dec_rd),
        .dec_rs1   (dec_rs1),
        .dec_rs2   (dec_rs2),
        .dec_imm   (dec_imm),
        .dec_fault (dec_fault)
    );

    // ----------------------------------------------------------------------
    // reporting

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Checks failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            abort_run($sformatf("FAILED at %0t ns: %s expected 0x%0h got 0x%0h",
                                $time, name, expected, actual));
        end
    endtask

    // ----------------------------------------------------------------------
    // reference predecoder, straight from the RV32I encodings

    function automatic void ref_decode(input instr_t w, input logic fault,
                                       output logic [3:0] cls, output reg_idx_t rd,
                                       output reg_idx_t rs1, output reg_idx_t rs2,
                                       output imm_t imm);
        logic [11:0] s_imm;
        logic [12:0] b_imm;
        logic [20:0] j_imm;
        s_imm = {w[31:25], w[11:7]};
        b_imm = {w[31], w[7], w[30:25], w[11:8], 1'b0};
        j_imm = {w[31], w[19:12], w[20], w[30:21], 1'b0};
        rd  = w[11:7];
        rs1 = w[19:15];
        rs2 = w[24:20];
        case (w[6:0])
            7'h37: begin cls = CLASS_LUI;     imm = {w[31:12], 12'h000}; end
            7'h17: begin cls = CLASS_AUIPC;   imm = {w[31:12], 12'h000}; end
            7'h6f: begin cls = CLASS_JAL;     imm = {{11{j_imm[20]}}, j_imm}; end
            7'h67: begin cls = CLASS_JALR;    imm = $signed(w) >>> 20; end
            7'h63: begin cls = CLASS_BRANCH;  imm = {{19{b_imm[12]}}, b_imm}; end
            7'h03: begin cls = CLASS_LOAD;    imm = $signed(w) >>> 20; end
            7'h23: begin cls = CLASS_STORE;   imm = {{20{s_imm[11]}}, s_imm}; end
            7'h13: begin cls = CLASS_ALU_IMM; imm = $signed(w) >>> 20; end
            7'h33: begin cls = CLASS_ALU_REG; imm = '0; end
            7'h73: begin cls = CLASS_SYSTEM;  imm = $signed(w) >>> 20; end
            default: begin cls = CLASS_ILLEGAL; imm = '0; end
        endcase
        if (fault) begin
            cls = CLASS_ILLEGAL;
            rd  = '0;
            rs1 = '0;
            rs2 = '0;
            imm = '0;
        end
    endfunction

    // ----------------------------------------------------------------------
    // memory model, a wishbone classic slave with random wait states

    task automatic fill_memory();
        instr_t bits;
        int     k;
        opcode_table = '{7'h37, 7'h17, 7'h6f, 7'h67, 7'h63, 7'h03,
                         7'h23, 7'h13, 7'h33, 7'h73, 7'h7f};
        for (int i = 0; i < NUM_WORDS; i++) begin
            bits   = $random(seed);
            k      = ($random(seed) & 32'h7fff_ffff) % 11;
            mem[i] = {bits[31:7], opcode_table[k]};
        end
    endtask

    task automatic memory_step();
        logic        responding;
        logic [31:0] idx;
        responding = wb_ack || wb_err;
        wb_ack     = 1'b0;
        wb_err     = 1'b0;
        if (wb_stb && !responding) begin
            if (!wait_armed) begin
                wait_left  = $random(seed) & 3;
                wait_armed = 1'b1;
            end
            if (wait_left == 0) begin
                wait_armed = 1'b0;
                idx        = (wb_adr - BOOT_PC) >> 2;
                // data is still driven on err, the fetch stage must drop it
                wb_dat_r   = mem[idx[7:0]];
                if (idx >= 100 && idx <= 103) begin
                    wb_err = 1'b1;
                end else begin
                    wb_ack = 1'b1;
                end
            end else begin
                wait_left--;
            end
        end
    endtask

    // ----------------------------------------------------------------------
    // consumer side, compares every accepted output in order

    task automatic check_held();
        check_value("dec_pc (held)", dec_pc, held_pc);
        check_value("dec_class (held)", 32'(dec_class), 32'(held_class));
        check_value("dec_rd (held)", 32'(dec_rd), 32'(held_rd));
        check_value("dec_rs1 (held)", 32'(dec_rs1), 32'(held_rs1));
        check_value("dec_rs2 (held)", 32'(dec_rs2), 32'(held_rs2));
        check_value("dec_imm (held)", dec_imm, held_imm);
        check_value("dec_fault (held)", 32'(dec_fault), 32'(held_fault));
    endtask

    task automatic check_accepted();
        logic       is_fault;
        logic [3:0] e_class;
        reg_idx_t   e_rd;
        reg_idx_t   e_rs1;
        reg_idx_t   e_rs2;
        imm_t       e_imm;
        is_fault = (accepted >= 100) && (accepted <= 103);
        ref_decode(mem[accepted], is_fault, e_class, e_rd, e_rs1, e_rs2, e_imm);
        check_value("dec_pc", dec_pc, BOOT_PC + 32'(4 * accepted));
        check_value("dec_class", 32'(dec_class), 32'(e_class));
        check_value("dec_rd", 32'(dec_rd), 32'(e_rd));
        check_value("dec_rs1", 32'(dec_rs1), 32'(e_rs1));
        check_value("dec_rs2", 32'(dec_rs2), 32'(e_rs2));
        check_value("dec_imm", dec_imm, e_imm);
        check_value("dec_fault", 32'(dec_fault), 32'(is_fault));
        if (is_fault) begin
            fault_words++;
        end
        accepted++;
    endtask

    task automatic consumer_step();
        if (held) begin
            check_held();
        end
        // fetch has to come back soon after the long stall
        if (restart_wait) begin
            if (wb_cyc) begin
                restart_wait = 1'b0;
                stall_done   = 1'b1;
            end else begin
                restart_cycles++;
                if (restart_cycles > 8) begin
                    abort_run("ERROR: fetch did not resume bus requests after the stall");
                end
            end
        end
        if (stall_left > 0) begin
            stall_left--;
            if (stall_left == 0) begin
                if (bus_beats - beats_at_stall > QUEUE_DEPTH + 2) begin
                    abort_run("ERROR: fetch kept issuing bus cycles during the stall");
                end
                check_value("wb_cyc", 32'(wb_cyc), 32'd0);
                check_value("wb_stb", 32'(wb_stb), 32'd0);
                restart_wait   = 1'b1;
                restart_cycles = 0;
            end
        end else if (accepted == STALL_AT && !stall_started) begin
            stall_started  = 1'b1;
            stall_left     = STALL_CYCLES;
            beats_at_stall = bus_beats;
        end
        if (stall_left > 0) begin
            dec_ready = 1'b0;
        end else begin
            dec_ready = (($random(seed) & 3) != 0);
        end
        // the next rising edge samples this ready together with the outputs
        if (dec_valid && dec_ready) begin
            check_accepted();
        end
        held       = dec_valid && !dec_ready;
        held_pc    = dec_pc;
        held_class = dec_class;
        held_rd    = dec_rd;
        held_rs1   = dec_rs1;
        held_rs2   = dec_rs2;
        held_imm   = dec_imm;
        held_fault = dec_fault;
    endtask

    // ----------------------------------------------------------------------
    // bus beat counter and timeout

    always @(posedge CLK) begin
        if (wb_ack || wb_err) begin
            bus_beats++;
        end
        if (nRST) begin
            cycles++;
        end
        if (cycles > TIMEOUT_CYCLES) begin
            abort_run("ERROR: timeout, not all words came out of the front end");
        end
    end

    // ----------------------------------------------------------------------
    // main sequence

    initial begin
        seed          = 40976;
        nRST          = 1'b0;
        dec_ready     = 1'b0;
        wb_dat_r      = '0;
        wb_ack        = 1'b0;
        wb_err        = 1'b0;
        wait_left     = 0;
        wait_armed    = 1'b0;
        accepted      = 0;
        fault_words   = 0;
        cycles        = 0;
        bus_beats     = 0;
        stall_left    = 0;
        stall_started = 1'b0;
        restart_wait  = 1'b0;
        stall_done    = 1'b0;
        held          = 1'b0;
        fill_memory();

        repeat (16) begin
            @(negedge CLK);
            check_value("wb_cyc", 32'(wb_cyc), 32'd0);
            check_value("wb_stb", 32'(wb_stb), 32'd0);
            check_value("dec_valid", 32'(dec_valid), 32'd0);
        end
        nRST = 1'b1;

        // first request opens on the first edge after release
        @(negedge CLK);
        check_value("wb_cyc", 32'(wb_cyc), 32'd1);
        check_value("wb_stb", 32'(wb_stb), 32'd1);
        check_value("wb_adr", wb_adr, BOOT_PC);
        check_value("dec_valid", 32'(dec_valid), 32'd0);
        memory_step();
        consumer_step();

        while (accepted < NUM_WORDS) begin
            @(negedge CLK);
            memory_step();
            consumer_step();
        end

        if (fault_words == 4 && stall_done) begin
            $display("All checks passed");
            $finish;
        end else begin
            abort_run($sformatf("ERROR: saw %0d faulted words and stall_done=%0b",
                                fault_words, stall_done));
        end
    end

endmodule

// ==== files.f ====
src/frontend_pkg.sv
src/q_fast_ready.sv
src/fetch_wb_master.sv
src/predecode_stage.sv
src/frontend_top.sv
verification/tb_clock_gen.sv
verification/frontend_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the front end testbench with verilator, pass or fail from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f files.f --top-module frontend_tb \
    -o frontend_tb_sim > build.log 2>&1 \
    && ./obj_dir/frontend_tb_sim > sim.log 2>&1 \
    || { cat build.log; echo "build or run failed"; }
cat sim.log 2>/dev/null
grep -q "All checks passed" sim.log 2>/dev/null && echo "PASS" || { echo "FAIL"; exit 1; }
